/* source/mips_ex_consts.svh */
/*
 * Widths and MIPS encodings for the execute stage.
 * Opcode and funct values follow the standard MIPS32 tables.
 * Only the listed instructions are decoded; anything else maps to no-op.
 */
`ifndef MIPS_EX_CONSTS_SVH
`define MIPS_EX_CONSTS_SVH

`define DATA_W          32              // datapath width
`define IMM_W           16              // i-format immediate
`define OPC_W           6               // opcode field
`define FUNCT_W         6               // r-format funct field

`define OPC_RTYPE       6'h00           // r-format, op picked by funct
`define OPC_ADDI        6'h08
`define OPC_ANDI        6'h0c
`define OPC_ORI         6'h0d
`define OPC_LW          6'h23           // address = rs + sext(imm)
`define OPC_SW          6'h2b           // same address calc as lw
`define OPC_BEQ         6'h04           // compare by subtract

`define FN_ADD          6'h20
`define FN_SUB          6'h22
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_XOR          6'h26
`define FN_NOR          6'h27
`define FN_SLT          6'h2a

`endif

/* source/mips_ex_pkg.sv */
/*
 * Shared types for the execute stage.
 * ALU control codes keep the classic MIPS ALU control encoding.
 * ALU_NONE is the catch-all for undecoded instructions.
 */
`include "mips_ex_consts.svh"

package mips_ex_pkg;

        // alu operation select, 4-bit classic encoding
        typedef enum logic [3:0]
        {
                ALU_AND  = 4'b0000,
                ALU_OR   = 4'b0001,
                ALU_ADD  = 4'b0010,
                ALU_SUB  = 4'b0110,
                ALU_SLT  = 4'b0111,
                ALU_NOR  = 4'b1100,
                ALU_XOR  = 4'b1101,
                ALU_NONE = 4'b1111                      // unsupported op
        } alu_ctrl_t;

        typedef logic [`OPC_W-1:0]   opcode_t;          // instr[31:26]
        typedef logic [`FUNCT_W-1:0] funct_t;           // instr[5:0]
        typedef logic [`DATA_W-1:0]  word_t;            // register word

endpackage

/* source/add_sub_unit.sv */
/*
 * Ripple-carry adder, one full adder per bit.
 * Subtract by feeding ~b with ci = 1 from the caller.
 * Delay grows linearly with N; fine for a teaching pipeline.
 */
`include "mips_ex_consts.svh"

module add_sub_unit
#(
        parameter int N = `DATA_W
)
(
        input  logic [N-1:0] a,
        input  logic [N-1:0] b,
        input  logic         ci,
        output logic [N-1:0] s,
        output logic         co
);

        logic [N:0] c;                          // carry chain, c[0] is carry in

        assign c[0] = ci;

        genvar i;
        generate
                for (i = 0; i < N; i++)
                begin : g_bit
                        assign s[i]   = a[i] ^ b[i] ^ c[i];                     // sum bit
                        assign c[i+1] = (a[i] & b[i]) | (c[i] & (a[i] ^ b[i])); // carry out
                end
        endgenerate

        assign co = c[N];                       // msb carry

endmodule

/* source/alu.sv */
/*
 * Combinational ALU: and, or, add, sub, slt, nor, xor.
 * slt takes the sign of a - b and ignores overflow, so it is not a
 * true signed compare near the range limits.
 * ALU_NONE and unknown codes give result 0 and zero 1.
 */
`include "mips_ex_consts.svh"

module alu
#(
        parameter int W = `DATA_W
)
(
        input  logic [W-1:0]            a,
        input  logic [W-1:0]            b,
        input  mips_ex_pkg::alu_ctrl_t  ctrl,
        output logic [W-1:0]            result,
        output logic                    zero
);

        import mips_ex_pkg::*;

        logic           sub_sel;                // 1 = subtract
        logic [W-1:0]   b_adder;                // b or ~b into the adder
        logic [W-1:0]   sum;                    // adder output

        assign sub_sel = (ctrl == ALU_SUB) || (ctrl == ALU_SLT);
        assign b_adder = sub_sel ? ~b : b;      // two's complement with ci

        add_sub_unit
        #(
                .N(W)
        )
        u_add_sub
        (
                .a  (a),
                .b  (b_adder),
                .ci (sub_sel),                  // +1 completes the negate
                .s  (sum),
                .co ()                          // no overflow/carry out used
        );

        always_comb
        begin
                case (ctrl)
                        ALU_AND:  result = a & b;
                        ALU_OR:   result = a | b;
                        ALU_ADD:  result = sum;
                        ALU_SUB:  result = sum;
                        ALU_SLT:  result = {{(W-1){1'b0}}, sum[W-1]};  // sign of a - b
                        ALU_NOR:  result = ~(a | b);
                        ALU_XOR:  result = a ^ b;
                        default:  result = '0;  // none
                endcase
        end

        assign zero = (result == '0);           // also 1 for none

        // the decode stage always hands over a resolved control code
        always_comb
        begin
                assert (!$isunknown(ctrl))
                else $error("alu: control code is unknown");
        end

endmodule

/* source/ex_decode.sv */
/*
 * ALU control decode, operand select and the ID/EX register.
 * in_valid is a one-cycle strobe; no back-pressure, a new
 * instruction may arrive every cycle.
 * Operand registers hold their last value while in_valid is low.
 */
`include "mips_ex_consts.svh"

module ex_decode
(
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    in_valid,
        input  mips_ex_pkg::opcode_t    opcode,
        input  mips_ex_pkg::funct_t     funct,
        input  mips_ex_pkg::word_t      rs_data,
        input  mips_ex_pkg::word_t      rt_data,
        input  logic [`IMM_W-1:0]       imm,
        output logic                    ex_valid,
        output mips_ex_pkg::alu_ctrl_t  ex_ctrl,
        output mips_ex_pkg::word_t      ex_a,
        output mips_ex_pkg::word_t      ex_b,
        output logic                    ex_is_beq
);

        import mips_ex_pkg::*;

        alu_ctrl_t      dec_ctrl;               // decoded alu op
        logic           use_imm;                // b from immediate
        logic           imm_zext;               // zero- rather than sign-extend
        logic           dec_beq;                // branch compare
        word_t          imm_ext;                // extended immediate
        word_t          op_b;                   // selected second operand

        // r-format funct mapping
        function automatic alu_ctrl_t funct_to_ctrl(input funct_t fn);
                case (fn)
                        `FN_ADD: return ALU_ADD;
                        `FN_SUB: return ALU_SUB;
                        `FN_AND: return ALU_AND;
                        `FN_OR:  return ALU_OR;
                        `FN_XOR: return ALU_XOR;
                        `FN_NOR: return ALU_NOR;
                        `FN_SLT: return ALU_SLT;
                        default: return ALU_NONE;       // shifts etc. unsupported
                endcase
        endfunction

        always_comb
        begin
                dec_ctrl = ALU_NONE;            // default for unknown opcodes
                use_imm  = 1'b0;
                imm_zext = 1'b0;
                dec_beq  = 1'b0;
                case (opcode)
                        `OPC_RTYPE:
                        begin
                                dec_ctrl = funct_to_ctrl(funct);
                        end
                        `OPC_ADDI, `OPC_LW, `OPC_SW:
                        begin
                                dec_ctrl = ALU_ADD;     // add / address calc
                                use_imm  = 1'b1;
                        end
                        `OPC_ANDI:
                        begin
                                dec_ctrl = ALU_AND;
                                use_imm  = 1'b1;
                                imm_zext = 1'b1;        // logical imm is unsigned
                        end
                        `OPC_ORI:
                        begin
                                dec_ctrl = ALU_OR;
                                use_imm  = 1'b1;
                                imm_zext = 1'b1;
                        end
                        `OPC_BEQ:
                        begin
                                dec_ctrl = ALU_SUB;     // rs - rt, zero means equal
                                dec_beq  = 1'b1;
                        end
                        default:
                        begin
                                dec_ctrl = ALU_NONE;
                        end
                endcase
        end

        assign imm_ext = imm_zext ? {{(`DATA_W-`IMM_W){1'b0}}, imm}
                                  : {{(`DATA_W-`IMM_W){imm[`IMM_W-1]}}, imm};
        assign op_b    = use_imm ? imm_ext : rt_data;

        // control half of id/ex
        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        ex_valid  <= 1'b0;
                        ex_ctrl   <= ALU_NONE;
                        ex_is_beq <= 1'b0;
                end
                else
                begin
                        ex_valid <= in_valid;   // one-cycle strobe follows input
                        if (in_valid)
                        begin
                                ex_ctrl   <= dec_ctrl;
                                ex_is_beq <= dec_beq;
                        end
                end
        end

        // operand half of id/ex
        always_ff @(posedge clk)
        begin
                if (in_valid)
                begin
                        ex_a <= rs_data;
                        ex_b <= op_b;
                end
        end

        // every accepted instruction reaches the ex stage on the next edge, never later
        a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
                $past(rst_n) |-> (ex_valid == $past(in_valid)))
                else $error("ex_decode: ex_valid does not follow in_valid by one cycle");

endmodule

/* source/ex_result_stage.sv */
/*
 * ALU plus the EX/MEM result register.
 * beq is taken when the subtract gives zero.
 * Outputs hold until the next out_valid strobe.
 */
`include "mips_ex_consts.svh"

module ex_result_stage
(
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    ex_valid,
        input  mips_ex_pkg::alu_ctrl_t  ex_ctrl,
        input  mips_ex_pkg::word_t      ex_a,
        input  mips_ex_pkg::word_t      ex_b,
        input  logic                    ex_is_beq,
        output logic                    out_valid,
        output mips_ex_pkg::word_t      result,
        output logic                    zero,
        output logic                    branch_taken
);

        import mips_ex_pkg::*;

        word_t  alu_result;                     // comb alu output
        logic   alu_zero;

        alu
        #(
                .W(`DATA_W)
        )
        u_alu
        (
                .a      (ex_a),
                .b      (ex_b),
                .ctrl   (ex_ctrl),
                .result (alu_result),
                .zero   (alu_zero)
        );

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        out_valid    <= 1'b0;
                        result       <= '0;
                        zero         <= 1'b0;
                        branch_taken <= 1'b0;
                end
                else
                begin
                        out_valid <= ex_valid;
                        if (ex_valid)
                        begin
                                result       <= alu_result;
                                zero         <= alu_zero;
                                branch_taken <= ex_is_beq & alu_zero;   // equal operands
                        end
                end
        end

        // a taken branch must come from a zero compare, even across held cycles
        a_taken_zero: assert property (@(posedge clk) disable iff (!rst_n)
                branch_taken |-> zero)
                else $error("ex_result_stage: branch taken without zero");

endmodule

/* source/mips_ex_top.sv */
/*
 * Execute stage top: decode/ID-EX, then ALU/result register.
 * Latency is 2 edges from in_valid to out_valid; up to two
 * instructions in flight, no stalls and no forwarding.
 */
`include "mips_ex_consts.svh"

module mips_ex_top
(
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    in_valid,
        input  mips_ex_pkg::opcode_t    opcode,
        input  mips_ex_pkg::funct_t     funct,
        input  mips_ex_pkg::word_t      rs_data,
        input  mips_ex_pkg::word_t      rt_data,
        input  logic [`IMM_W-1:0]       imm,
        output logic                    out_valid,
        output mips_ex_pkg::word_t      result,
        output logic                    zero,
        output logic                    branch_taken
);

        import mips_ex_pkg::*;

        logic           ex_valid;               // id/ex stage
        alu_ctrl_t      ex_ctrl;
        word_t          ex_a;
        word_t          ex_b;
        logic           ex_is_beq;

        ex_decode u_decode
        (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .opcode    (opcode),
                .funct     (funct),
                .rs_data   (rs_data),
                .rt_data   (rt_data),
                .imm       (imm),
                .ex_valid  (ex_valid),
                .ex_ctrl   (ex_ctrl),
                .ex_a      (ex_a),
                .ex_b      (ex_b),
                .ex_is_beq (ex_is_beq)
        );

        ex_result_stage u_result
        (
                .clk          (clk),
                .rst_n        (rst_n),
                .ex_valid     (ex_valid),
                .ex_ctrl      (ex_ctrl),
                .ex_a         (ex_a),
                .ex_b         (ex_b),
                .ex_is_beq    (ex_is_beq),
                .out_valid    (out_valid),
                .result       (result),
                .zero         (zero),
                .branch_taken (branch_taken)
        );

endmodule

/* test/tb_mips_ex.sv */
/*
 * Testbench for mips_ex_top with vectors from test/ex_stimulus.txt.
 * Each vector is eight hex words, and an opcode word above 0x3f ends the list.
 * Inputs change on the falling edge and outputs are checked there too.
 * Stops at the first error.
 */
`include "mips_ex_consts.svh"

module tb_mips_ex;

        timeunit 1ns;
        timeprecision 100ps;

        import mips_ex_pkg::*;

        localparam int FIELDS  = 8;             // words per vector
        localparam int MAX_VEC = 64;
        localparam int RST_CYC = 16;
        localparam int BURST   = 6;             // leading vectors sent back to back

        logic                   clk;
        logic                   rst_n;
        logic                   in_valid;
        opcode_t                opcode;
        funct_t                 funct;
        word_t                  rs_data;
        word_t                  rt_data;
        logic [`IMM_W-1:0]      imm;
        logic                   out_valid;
        word_t                  result;
        logic                   zero;
        logic                   branch_taken;

        logic [31:0]    vec_mem [0:MAX_VEC*FIELDS-1];
        int             nvec;                   // vectors found in the file
        int             seed;
        int             cyc;                    // posedges since reset release
        int             idx_q[$];               // vectors in flight
        int             due_q[$];               // cyc value when each result is due
        logic           loaded;
        logic           seen_out;
        word_t          last_result;            // expected hold values
        logic           last_zero;
        logic           last_branch;

        mips_ex_top dut
        (
                .clk          (clk),
                .rst_n        (rst_n),
                .in_valid     (in_valid),
                .opcode       (opcode),
                .funct        (funct),
                .rs_data      (rs_data),
                .rt_data      (rt_data),
                .imm          (imm),
                .out_valid    (out_valid),
                .result       (result),
                .zero         (zero),
                .branch_taken (branch_taken)
        );

        initial
        begin
                clk = 1'b0;
                forever #4 clk = ~clk;          // 8 ns period
        end

        always @(posedge clk)
        begin
                if (!rst_n)
                        cyc <= 0;
                else
                        cyc <= cyc + 1;
        end

        task automatic stop_on_failure();
                $display("SOME TESTS FAILED");
                $fatal(1, "run stopped at %0t ns", $time);
        endtask

        task automatic check_word(input word_t actual, input word_t expected, input string what);
                if (actual !== expected)
                begin
                        $display("[ERROR] %0t ns: %s is %h, expected %h",
                                 $time, what, actual, expected);
                        stop_on_failure();
                end
        endtask

        task automatic check_flag(input logic actual, input logic expected, input string name);
                if (actual !== expected)
                begin
                        $display("[ERROR] %0t ns: %s is %b, expected %b",
                                 $time, name, actual, expected);
                        stop_on_failure();
                end
        endtask

        // time budget grows with the vector count
        initial
        begin
                wait (loaded === 1'b1);
                #((RST_CYC + 4 * nvec + 10) * 8);
                $display("timeout: the run did not finish within %0d clock cycles",
                         RST_CYC + 4 * nvec + 10);
                stop_on_failure();
        end

        // result monitor samples on the falling edge where outputs are stable
        always @(negedge clk)
        begin
                int     v;
                if (!rst_n)
                begin
                        seen_out <= 1'b0;
                end
                else if (out_valid)
                begin
                        if (idx_q.size() == 0)
                        begin
                                $display("out_valid rose at %0t ns with no instruction in flight",
                                         $time);
                                stop_on_failure();
                        end
                        else if (cyc != due_q[0])
                        begin
                                $display("out_valid at %0t ns came at cycle %0d, due at cycle %0d",
                                         $time, cyc, due_q[0]);
                                stop_on_failure();
                        end
                        else
                        begin
                                v = idx_q.pop_front();
                                void'(due_q.pop_front());
                                check_word(result, vec_mem[v*FIELDS+5],
                                           $sformatf("result of vector %0d", v));
                                check_flag(zero, vec_mem[v*FIELDS+6][0],
                                           $sformatf("zero of vector %0d", v));
                                check_flag(branch_taken, vec_mem[v*FIELDS+7][0],
                                           $sformatf("branch_taken of vector %0d", v));
                                seen_out    <= 1'b1;
                                last_result <= vec_mem[v*FIELDS+5];
                                last_zero   <= vec_mem[v*FIELDS+6][0];
                                last_branch <= vec_mem[v*FIELDS+7][0];
                        end
                end
                else if (idx_q.size() != 0 && cyc >= due_q[0])
                begin
                        $display("out_valid missing at %0t ns for vector %0d", $time, idx_q[0]);
                        stop_on_failure();
                end
                else if (seen_out)
                begin
                        check_word(result, last_result, "held result");
                        check_flag(zero, last_zero, "held zero");
                        check_flag(branch_taken, last_branch, "held branch_taken");
                end
        end

        initial
        begin
                int     base;
                int     idle;
                rst_n    = 1'b0;
                in_valid = 1'b0;
                opcode   = '0;
                funct    = '0;
                rs_data  = '0;
                rt_data  = '0;
                imm      = '0;
                loaded   = 1'b0;
                seed     = 33294;
                for (int i = 0; i < MAX_VEC * FIELDS; i++)
                begin
                        vec_mem[i] = 32'hffff0000 | i;  // unread rows read as end of list
                end
                $readmemh("test/ex_stimulus.txt", vec_mem);
                nvec = 0;
                while (nvec < MAX_VEC && vec_mem[nvec * FIELDS] <= 32'h3f)
                begin
                        nvec++;
                end
                if (nvec == 0)
                begin
                        $display("no vectors were found in test/ex_stimulus.txt");
                        stop_on_failure();
                end
                loaded = 1'b1;

                repeat (RST_CYC) @(posedge clk);
                @(negedge clk);
                check_flag(out_valid, 1'b0, "out_valid after reset");
                check_word(result, '0, "result after reset");
                check_flag(zero, 1'b0, "zero after reset");
                check_flag(branch_taken, 1'b0, "branch_taken after reset");
                rst_n = 1'b1;

                for (int v = 0; v < nvec; v++)
                begin
                        base     = v * FIELDS;
                        opcode   = vec_mem[base][`OPC_W-1:0];
                        funct    = vec_mem[base+1][`FUNCT_W-1:0];
                        rs_data  = vec_mem[base+2];
                        rt_data  = vec_mem[base+3];
                        imm      = vec_mem[base+4][`IMM_W-1:0];
                        in_valid = 1'b1;
                        idx_q.push_back(v);
                        due_q.push_back(cyc + 2);       // due after sampling edge and result edge
                        if (v < BURST)
                                idle = 0;
                        else
                                idle = $unsigned($random(seed)) % 4;
                        @(negedge clk);
                        in_valid = 1'b0;
                        repeat (idle)
                        begin
                                rs_data = $random(seed);        // junk operands while idle
                                rt_data = $random(seed);
                                @(negedge clk);
                        end
                end

                for (int k = 0; k < 4 && idx_q.size() != 0; k++)
                begin
                        @(negedge clk);
                end
                repeat (2) @(negedge clk);      // a stray out_valid shows up here

                if (idx_q.size() != 0)
                begin
                        $display("%0d results never arrived", idx_q.size());
                        stop_on_failure();
                end
                else
                begin
                        $display("ALL TESTS PASSED");
                        $finish;
                end
        end

endmodule

/* test/ex_stimulus.txt */
// columns, hex: opcode funct rs_data rt_data imm exp_result exp_zero exp_branch
// a row with an opcode word above 3f ends the list
00 20 00000005 00000003 1234 00000008 0 0 // add, imm ignored
00 20 ffffffff 00000001 0000 00000000 1 0 // add wraps to zero, no branch
00 20 7fffffff 00000001 0000 80000000 0 0
00 22 0000000a 00000003 0000 00000007 0 0
00 22 00000000 00000001 0000 ffffffff 0 0 // sub wraps
00 22 12345678 12345678 0000 00000000 1 0 // equal sub, no branch
00 24 f0f0f0f0 ff00ff00 0000 f000f000 0 0
00 25 f0f0f0f0 0f0f0000 0000 fffff0f0 0 0
00 26 aaaaaaaa 55555555 0000 ffffffff 0 0
00 26 a5a5a5a5 a5a5a5a5 0000 00000000 1 0
00 27 00000000 00000000 0000 ffffffff 0 0
00 27 f0f0f0f0 0f0f0f0f 0000 00000000 1 0
00 2a 00000003 00000005 0000 00000001 0 0
00 2a 00000005 00000003 0000 00000000 1 0
00 2a ffffffff 00000001 0000 00000001 0 0
00 2a 00000001 ffffffff 0000 00000000 1 0
00 2a 80000000 00000001 0000 00000000 1 0 // overflow, sign of diff is 0
00 2a 7fffffff ffffffff 0000 00000001 0 0 // overflow, sign of diff is 1
00 2a 00000005 00000005 0000 00000000 1 0
08 00 00000010 deadbeef 0005 00000015 0 0 // addi, rt ignored
08 00 00000010 00000000 fff0 00000000 1 0
08 00 00000005 00000000 ffff 00000004 0 0
23 00 10000000 00000000 0004 10000004 0 0 // lw
23 00 10000000 00000000 fffc 0ffffffc 0 0
2b 00 20000000 00000000 8000 1fff8000 0 0 // sw
2b 00 00001000 00000000 0010 00001010 0 0
0c 00 ffffffff 00000000 ffff 0000ffff 0 0 // andi zero-extends
0c 00 12345678 00000000 00f0 00000070 0 0
0d 00 00000000 00000000 8000 00008000 0 0 // ori zero-extends
0d 00 12340000 00000000 abcd 1234abcd 0 0
04 00 00000042 00000042 0010 00000000 1 1 // beq taken
04 00 00000042 00000043 0000 ffffffff 0 0
04 00 ffffffff ffffffff 0000 00000000 1 1
04 00 00000001 00000000 0000 00000001 0 0
3f 00 00000007 00000007 0001 00000000 1 0 // unsupported opcode
00 00 00000007 00000003 0000 00000000 1 0 // sll
00 21 00000007 00000003 0000 00000000 1 0 // addu
02 00 00000007 00000003 0000 00000000 1 0 // j
00 08 00000007 00000003 0000 00000000 1 0 // jr
ffffffff 0 0 0 0 0 0 0 // end of list

/* flist.f */
+incdir+source
source/mips_ex_pkg.sv
source/add_sub_unit.sv
source/alu.sv
source/ex_decode.sv
source/ex_result_stage.sv
source/mips_ex_top.sv
test/tb_mips_ex.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
        -f flist.f --top-module tb_mips_ex \
        -Mdir "$OBJ" -o tb_mips_ex > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
        cat "$BUILD_LOG"
        echo "build failed with status $build_status"
        exit 1
fi

"./$OBJ/tb_mips_ex" > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
        echo "simulation exited with status $run_status"
fi

if grep -q "^ALL TESTS PASSED$" "$SIM_LOG"; then
        exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
